// File: logic/frame_sequencer.sv
/*
 Frame state machine of the generator.
 Walks each frame through two header beats, the payload beats and a
 one-cycle gap, picks the payload length between frames, and keeps the
 sequence number and the transmitted-packet count. Everything except the
 idle start holds while tx_ready is low.
*/
`timescale 1ns/1ps
`include "pktgen_defines.svh"

module frame_sequencer (
   input  logic                     clk,
   input  logic                     reset,
   input  pktgen_pkg::gen_cfg_t     cfg,
   input  logic                     start,
   input  logic                     tx_ready,
   input  pktgen_pkg::payload_t     pay,
   output pktgen_pkg::frame_ctl_t   ctl,
   output logic                     load,
   output logic                     advance,
   output logic [`PKTGEN_REG_W-1:0] packet_tx_count
);

   import pktgen_pkg::*;

   gen_state_e  state;
   logic [15:0] payload_len;   // Length of the frame in flight
   logic [15:0] sel_len;       // Candidate for the next frame
   logic [15:0] seq_num;
   logic [15:0] bytes_left;    // Includes the current data beat
   logic        last_beat;

   // ------------------------------------------------------------------------
   // Length selection
   // ------------------------------------------------------------------------
   always_comb begin
      if (cfg.random_length) begin
         sel_len = 16'(pay.rand_len_bits % `PKTGEN_RAND_MOD);
      end else if (cfg.pkt_length < 14'(`PKTGEN_HDR_BYTES)) begin
         sel_len = '0;                                   // Header only
      end else if (cfg.pkt_length > 14'(`PKTGEN_MAX_LEN)) begin
         sel_len = 16'(`PKTGEN_CLAMP_PAYLOAD);
      end else begin
         sel_len = 16'(cfg.pkt_length) - 16'(`PKTGEN_HDR_BYTES);
      end
   end

   // ------------------------------------------------------------------------
   // State machine and counters
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state           <= idle;
         payload_len     <= '0;
         seq_num         <= '0;
         bytes_left      <= '0;
         last_beat       <= 1'b0;
         packet_tx_count <= '0;
      end else if (state == idle) begin
         payload_len <= sel_len;
         if (start) begin
            state           <= dest_src;
            seq_num         <= '0;
            packet_tx_count <= '0;
         end
      end else if (tx_ready) begin
         case (state)
            dest_src: state <= src_len_seq;
            src_len_seq: begin
               packet_tx_count <= packet_tx_count + 32'd1;
               bytes_left      <= payload_len;
               last_beat       <= (payload_len <= 16'd8);
               state           <= (payload_len == '0) ? gap : data;   // Empty frame ends here
            end
            data: begin
               bytes_left <= bytes_left - 16'd8;
               last_beat  <= (bytes_left <= 16'd16);
               if (last_beat) state <= gap;
            end
            gap: begin
               payload_len <= sel_len;
               seq_num     <= seq_num + 16'd1;
               if (cfg.stop || packet_tx_count == cfg.number_packet) state <= idle;
               else state <= dest_src;
            end
            default: state <= idle;
         endcase
      end
   end

   assign load    = (state == idle);               // Lanes sit on the seed
   assign advance = (state == data) & tx_ready;    // One word per data beat

   assign ctl.next_state  = state;
   assign ctl.payload_len = payload_len;
   assign ctl.seq_num     = seq_num;
   assign ctl.last_beat   = last_beat;

endmodule

// File: logic/payload_source.sv
/*
 Payload word source.
 Four PRBS lanes form a 92-bit random vector, next to a byte counting
 pattern. cfg picks which one feeds the data beats. Both restart on
 load and step once per accepted data beat.
*/
`timescale 1ns/1ps
`include "pktgen_defines.svh"

module payload_source (
   input  logic                 clk,
   input  logic                 reset,
   input  pktgen_pkg::gen_cfg_t cfg,
   input  logic                 load,      // Held in idle
   input  logic                 advance,   // Data beat taken
   output pktgen_pkg::payload_t pay
);

   logic [`PKTGEN_SEED_W-1:0] lanes;     // Concatenated lane states
   logic [`PKTGEN_DATA_W-1:0] pattern;   // Incrementing bytes

   for (genvar g = 0; g < 4; g++) begin : g_lane
      prbs23_lane u_lane (
         .clk     (clk),
         .reset   (reset),
         .load    (load),
         .advance (advance),
         .seed    (cfg.seed[23*g +: 23]),
         .state   (lanes[23*g +: 23])
      );
   end

   // Every byte steps by 8, so F8..FF rolls over to 00..07 by itself
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pattern <= 64'h0001_0203_0405_0607;
      end else if (load) begin
         pattern <= 64'h0001_0203_0405_0607;
      end else if (advance) begin
         for (int b = 0; b < 8; b++) begin
            pattern[8*b +: 8] <= pattern[8*b +: 8] + 8'h08;
         end
      end
   end

   assign pay.word          = cfg.random_payload ? lanes[63:0] : pattern;
   assign pay.rand_len_bits = lanes[74:64];   // Length draw for the next frame

endmodule

// File: logic/pktgen_csr.sv
/*
 Register bank of the packet generator.
 Decodes host accesses on the 32-bit register port, raises waitrequest
 for the first cycle of each access, registers readback data and
 forms the one-cycle start pulse. All settings leave as one cfg struct.
*/
`timescale 1ns/1ps
`include "pktgen_defines.svh"

module pktgen_csr (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [7:0]               address,
   input  logic                     write,
   input  logic                     read,
   input  logic [`PKTGEN_REG_W-1:0] writedata,
   output logic [`PKTGEN_REG_W-1:0] readdata,
   output logic                     waitrequest,
   input  logic [`PKTGEN_REG_W-1:0] packet_tx_count,
   output pktgen_pkg::gen_cfg_t     cfg,
   output logic                     start
);

   logic wr_d;      // Strobes one cycle late
   logic rd_d;
   logic wr_edge;   // First cycle of a write
   logic rd_edge;

   // ------------------------------------------------------------------------
   // Access detection
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_d <= 1'b0;
         rd_d <= 1'b0;
      end else begin
         wr_d <= write;
         rd_d <= read;
      end
   end

   assign wr_edge     = write & ~wr_d;
   assign rd_edge     = read & ~rd_d;
   assign waitrequest = wr_edge | rd_edge;   // Drops in the second cycle

   // ------------------------------------------------------------------------
   // Register writes
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cfg      <= '0;
         cfg.seed <= {`PKTGEN_SEED2_RST, `PKTGEN_SEED1_RST, `PKTGEN_SEED0_RST};
         start    <= 1'b0;
      end else begin
         start <= 1'b0;                                     // Pulse only
         if (wr_edge) begin
            case (address)
               `PKTGEN_ADDR_NUMPKTS:       cfg.number_packet  <= writedata;
               `PKTGEN_ADDR_RANDOMLENGTH:  cfg.random_length  <= writedata[0];
               `PKTGEN_ADDR_RANDOMPAYLOAD: cfg.random_payload <= writedata[0];
               `PKTGEN_ADDR_START:         start              <= writedata[0];
               `PKTGEN_ADDR_STOP:          cfg.stop           <= writedata[0];
               `PKTGEN_ADDR_MACSA0:        cfg.mac_sa[31:0]   <= writedata;
               `PKTGEN_ADDR_MACSA1:        cfg.mac_sa[47:32]  <= writedata[15:0];
               `PKTGEN_ADDR_MACDA0:        cfg.mac_da[31:0]   <= writedata;
               `PKTGEN_ADDR_MACDA1:        cfg.mac_da[47:32]  <= writedata[15:0];
               `PKTGEN_ADDR_RNDSEED0:      cfg.seed[31:0]     <= writedata;
               `PKTGEN_ADDR_RNDSEED1:      cfg.seed[63:32]    <= writedata;
               `PKTGEN_ADDR_RNDSEED2:      cfg.seed[91:64]    <= writedata[27:0];
               `PKTGEN_ADDR_PKTLENGTH:     cfg.pkt_length     <= writedata[13:0];
               default: ;                                   // Counter is read only
            endcase
         end
      end
   end

   // ------------------------------------------------------------------------
   // Readback, captured in the first cycle of a read
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (rd_edge) begin
         case (address)
            `PKTGEN_ADDR_NUMPKTS:       readdata <= cfg.number_packet;
            `PKTGEN_ADDR_RANDOMLENGTH:  readdata <= {31'd0, cfg.random_length};
            `PKTGEN_ADDR_RANDOMPAYLOAD: readdata <= {31'd0, cfg.random_payload};
            `PKTGEN_ADDR_START:         readdata <= {31'd0, start};
            `PKTGEN_ADDR_STOP:          readdata <= {31'd0, cfg.stop};
            `PKTGEN_ADDR_MACSA0:        readdata <= cfg.mac_sa[31:0];
            `PKTGEN_ADDR_MACSA1:        readdata <= {16'd0, cfg.mac_sa[47:32]};
            `PKTGEN_ADDR_MACDA0:        readdata <= cfg.mac_da[31:0];
            `PKTGEN_ADDR_MACDA1:        readdata <= {16'd0, cfg.mac_da[47:32]};
            `PKTGEN_ADDR_TXPKTCNT:      readdata <= packet_tx_count;
            `PKTGEN_ADDR_RNDSEED0:      readdata <= cfg.seed[31:0];
            `PKTGEN_ADDR_RNDSEED1:      readdata <= cfg.seed[63:32];
            `PKTGEN_ADDR_RNDSEED2:      readdata <= {4'd0, cfg.seed[91:64]};
            `PKTGEN_ADDR_PKTLENGTH:     readdata <= {18'd0, cfg.pkt_length};
            default:                    readdata <= '0;
         endcase
      end
   end

endmodule

// File: logic/pktgen_defines.svh
/*
 Register map and sizing constants for the packet generator.
 Included by the package and by every module that needs an address,
 a width or a length limit.
*/
`ifndef PKTGEN_DEFINES_SVH
`define PKTGEN_DEFINES_SVH

// Register port addresses
`define PKTGEN_ADDR_NUMPKTS       8'h00
`define PKTGEN_ADDR_RANDOMLENGTH  8'h01
`define PKTGEN_ADDR_RANDOMPAYLOAD 8'h02
`define PKTGEN_ADDR_START         8'h03
`define PKTGEN_ADDR_STOP          8'h04
`define PKTGEN_ADDR_MACSA0        8'h05
`define PKTGEN_ADDR_MACSA1        8'h06
`define PKTGEN_ADDR_MACDA0        8'h07
`define PKTGEN_ADDR_MACDA1        8'h08
`define PKTGEN_ADDR_TXPKTCNT      8'h09
`define PKTGEN_ADDR_RNDSEED0      8'h0a
`define PKTGEN_ADDR_RNDSEED1      8'h0b
`define PKTGEN_ADDR_RNDSEED2      8'h0c
`define PKTGEN_ADDR_PKTLENGTH     8'h0d

`define PKTGEN_DATA_W        64     // Stream beat width
`define PKTGEN_REG_W         32     // Register port width
`define PKTGEN_SEED_W        92     // Four 23-bit PRBS lanes

`define PKTGEN_HDR_BYTES     24     // Header overhead taken off the fixed length
`define PKTGEN_MAX_LEN       9600   // Largest fixed length before clamping
`define PKTGEN_CLAMP_PAYLOAD 9576   // Payload used above that
`define PKTGEN_RAND_MOD      1495   // Modulus for random lengths
`define PKTGEN_SEQ_BYTES     2      // Sequence number counts in the length field

// Non-zero seeds so the PRBS runs without a seed write
`define PKTGEN_SEED0_RST 32'h5EED_0000
`define PKTGEN_SEED1_RST 32'h5EED_0001
`define PKTGEN_SEED2_RST 28'h002_5EED

`endif

// File: logic/pktgen_pkg.sv
/*
 Types shared by the packet generator blocks.
 Holds the frame state enum and the structs that carry the
 configuration, the frame control and the payload between modules.
*/
`include "pktgen_defines.svh"

package pktgen_pkg;

   // Beat the assembler produces next
   typedef enum logic [2:0] {
      idle        = 3'd0,
      dest_src    = 3'd1,   // DA and top of SA
      src_len_seq = 3'd2,   // Rest of SA, length, sequence
      data        = 3'd3,   // Payload beats
      gap         = 3'd4    // One idle cycle between frames
   } gen_state_e;

   // Register contents seen by the datapath
   typedef struct packed {
      logic [`PKTGEN_REG_W-1:0]  number_packet;
      logic                      random_length;
      logic                      random_payload;
      logic [13:0]               pkt_length;
      logic                      stop;
      logic [47:0]               mac_da;
      logic [47:0]               mac_sa;
      logic [`PKTGEN_SEED_W-1:0] seed;
   } gen_cfg_t;

   // Sequencer to assembler
   typedef struct packed {
      gen_state_e  next_state;
      logic [15:0] payload_len;
      logic [15:0] seq_num;
      logic        last_beat;   // Current data beat ends the frame
   } frame_ctl_t;

   typedef struct packed {
      logic [`PKTGEN_DATA_W-1:0] word;
      logic [10:0]               rand_len_bits;
   } payload_t;

endpackage

// File: logic/pktgen_top.sv
/*
 Top of the packet generator.
 Register bank, frame sequencer, payload source and beat assembler,
 wired between the host register port and the 64-bit stream.
*/
`timescale 1ns/1ps
`include "pktgen_defines.svh"

module pktgen_top (
   input  logic                      clk,
   input  logic                      reset,
   input  logic [7:0]                address,
   input  logic                      write,
   input  logic                      read,
   input  logic [`PKTGEN_REG_W-1:0]  writedata,
   output logic [`PKTGEN_REG_W-1:0]  readdata,
   output logic                      waitrequest,
   input  logic                      tx_ready,
   output logic [`PKTGEN_DATA_W-1:0] tx_data,
   output logic                      tx_valid,
   output logic                      tx_sop,
   output logic                      tx_eop,
   output logic [2:0]                tx_empty
);

   import pktgen_pkg::*;

   gen_cfg_t                 cfg;
   frame_ctl_t               ctl;
   payload_t                 pay;
   logic                     start;             // One-cycle run trigger
   logic                     load;
   logic                     advance;
   logic [`PKTGEN_REG_W-1:0] packet_tx_count;

   pktgen_csr u_csr (
      .clk, .reset, .address, .write, .read, .writedata, .readdata,
      .waitrequest, .packet_tx_count, .cfg, .start
   );

   frame_sequencer u_seq (
      .clk, .reset, .cfg, .start, .tx_ready, .pay, .ctl, .load, .advance,
      .packet_tx_count
   );

   payload_source u_src (.clk, .reset, .cfg, .load, .advance, .pay);

   tx_beat_assembler u_asm (
      .clk, .reset, .tx_ready, .ctl, .pay, .cfg,
      .tx_data, .tx_valid, .tx_sop, .tx_eop, .tx_empty
   );

endmodule

// File: logic/prbs23_lane.sv
/*
 One lane of the payload PRBS, polynomial x^23 + x^18 + 1.
 Each advance jumps 23 single-bit shifts so a lane yields 23 fresh bits
 per step. Load takes the seed and has priority over advance.
*/
`timescale 1ns/1ps

module prbs23_lane (
   input  logic        clk,
   input  logic        reset,
   input  logic        load,
   input  logic        advance,
   input  logic [22:0] seed,
   output logic [22:0] state
);

   logic [22:0] stepped;   // State after 23 shifts

   // Shift toward the LSB, feedback into the MSB
   always_comb begin
      stepped = state;
      for (int i = 0; i < 23; i++) begin
         stepped = {stepped[18] ^ stepped[0], stepped[22:1]};
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= '0;
      end else if (load) begin
         state <= seed;
      end else if (advance) begin
         state <= stepped;
      end
   end

endmodule

// File: logic/tx_beat_assembler.sv
/*
 Stream output stage.
 Turns the sequencer's beat selection into registered tx_* signals with
 the header fields or the payload word. All outputs advance only on
 tx_ready, so a stalled beat stays on the bus.
*/
`timescale 1ns/1ps
`include "pktgen_defines.svh"

module tx_beat_assembler (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      tx_ready,
   input  pktgen_pkg::frame_ctl_t    ctl,
   input  pktgen_pkg::payload_t      pay,
   input  pktgen_pkg::gen_cfg_t      cfg,
   output logic [`PKTGEN_DATA_W-1:0] tx_data,
   output logic                      tx_valid,
   output logic                      tx_sop,
   output logic                      tx_eop,
   output logic [2:0]                tx_empty
);

   import pktgen_pkg::*;

   logic [2:0] last_empty;   // Unused bytes in the closing beat

   assign last_empty = 3'(4'd8 - {1'b0, ctl.payload_len[2:0]});

   // ------------------------------------------------------------------------
   // Control outputs
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_valid <= 1'b0;
         tx_sop   <= 1'b0;
         tx_eop   <= 1'b0;
         tx_empty <= '0;
      end else if (tx_ready) begin
         tx_valid <= ctl.next_state inside {dest_src, src_len_seq, data};
         tx_sop   <= (ctl.next_state == dest_src);
         tx_eop   <= 1'b0;
         tx_empty <= '0;
         if (ctl.next_state == src_len_seq && ctl.payload_len == '0) begin
            tx_eop <= 1'b1;                      // Header only, full beat
         end
         if (ctl.next_state == data && ctl.last_beat) begin
            tx_eop   <= 1'b1;
            tx_empty <= last_empty;
         end
      end
   end

   // Beat contents, held through idle and gap
   always_ff @(posedge clk) begin
      if (tx_ready) begin
         case (ctl.next_state)
            dest_src:    tx_data <= {cfg.mac_da, cfg.mac_sa[47:32]};
            src_len_seq: tx_data <= {cfg.mac_sa[31:0],
                                     ctl.payload_len + 16'(`PKTGEN_SEQ_BYTES),
                                     ctl.seq_num};
            data:        tx_data <= pay.word;
            default: ;
         endcase
      end
   end

endmodule

// File: run.sh
#!/bin/sh
# Build the packet generator testbench with Verilator and run it.
# The run passes only if the log holds the pass line.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f src.f \
   --top-module pktgen_tb \
   --Mdir obj_dir \
   -o pktgen_sim

./obj_dir/pktgen_sim | tee sim.log

if grep -q "^Everything OK$" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

// File: src.f
+incdir+logic
logic/pktgen_pkg.sv
logic/pktgen_csr.sv
logic/prbs23_lane.sv
logic/payload_source.sv
logic/frame_sequencer.sv
logic/tx_beat_assembler.sv
logic/pktgen_top.sv
test/pktgen_checker.sv
test/pktgen_assert.sv
test/pktgen_tb.sv

// File: test/pktgen_assert.sv
/*
 Concurrent assertions on the generator handshakes.
 Bound into pktgen_top, so every instance of the top is covered.
*/
`timescale 1ns/1ps

module pktgen_assert (
   input logic        clk,
   input logic        reset,
   input logic        waitrequest,
   input logic        tx_ready,
   input logic        tx_valid,
   input logic        tx_sop,
   input logic        tx_eop,
   input logic [63:0] tx_data,
   input logic [2:0]  tx_empty
);

   // Stalled beat stays on the bus
   a_stream_hold: assert property (@(posedge clk) disable iff (reset)
      !tx_ready |=> $stable({tx_valid, tx_sop, tx_eop, tx_empty, tx_data}))
      else $error("stream outputs changed while tx_ready was low");

   a_wait_one_cycle: assert property (@(posedge clk) disable iff (reset)
      waitrequest |=> !waitrequest)                 // First cycle only
      else $error("waitrequest held past the first cycle of an access");

   a_marks_with_valid: assert property (@(posedge clk) disable iff (reset)
      (tx_sop || tx_eop) |-> tx_valid)
      else $error("tx_sop or tx_eop without tx_valid");

endmodule

bind pktgen_top pktgen_assert u_assert (
   .clk         (clk),
   .reset       (reset),
   .waitrequest (waitrequest),
   .tx_ready    (tx_ready),
   .tx_valid    (tx_valid),
   .tx_sop      (tx_sop),
   .tx_eop      (tx_eop),
   .tx_data     (tx_data),
   .tx_empty    (tx_empty)
);

// File: test/pktgen_checker.sv
/*
 Stream checker for the packet generator testbench.
 Keeps its own model of the run (PRBS lanes, byte pattern, frame length,
 sequence number) and compares every accepted beat with it. The testbench
 arms it before each start and also hands it register readback values.
*/
`timescale 1ns/1ps

module pktgen_checker (
   input logic        clk,
   input logic        reset,
   input logic        tx_ready,
   input logic        tx_valid,
   input logic        tx_sop,
   input logic        tx_eop,
   input logic [63:0] tx_data,
   input logic [2:0]  tx_empty,
   input logic        arm,        // Restart the model, next start follows
   input logic [47:0] cfg_da,
   input logic [47:0] cfg_sa,
   input logic [13:0] cfg_len,
   input logic        cfg_rlen,
   input logic        cfg_rpay,
   input logic [91:0] cfg_seed
);

   typedef struct packed {
      logic [63:0] data;
      logic        sop;
      logic        eop;
      logic [2:0]  empty;
   } beat_t;

   int          frames_seen   = 0;
   int          stream_errors = 0;
   int          value_errors  = 0;
   logic [91:0] lanes_m;      // Model of the four lanes
   int          pat_step;     // Data beats since load
   logic [15:0] frame_len;    // Payload bytes of the frame in flight
   logic [15:0] seq_m;
   int          beat_idx;     // 0 and 1 are the header beats

   // ------------------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------------------

   // Each lane takes 23 shifts of x^23 + x^18 + 1 per data beat
   function automatic logic [91:0] prbs_step(input logic [91:0] v);
      logic [91:0] r;
      logic [22:0] s;
      r = v;
      for (int g = 0; g < 4; g++) begin
         s = v[23*g +: 23];
         for (int i = 0; i < 23; i++) begin
            s = {s[18] ^ s[0], s[22:1]};   // New MSB from taps 18 and 0
         end
         r[23*g +: 23] = s;
      end
      return r;
   endfunction

   function automatic logic [15:0] pick_len(input logic [91:0] v);
      int n;
      if (cfg_rlen) begin
         n = int'(v[74:64]) % 1495;           // Random draw
      end else if (int'(cfg_len) < 24) begin
         n = 0;
      end else if (int'(cfg_len) > 9600) begin
         n = 9576;                            // Clamped
      end else begin
         n = int'(cfg_len) - 24;
      end
      return 16'(n);
   endfunction

   // Expected beat from its position in the frame
   function automatic beat_t expected_beat(input int beat, input logic [15:0] len,
                                           input logic [15:0] seq, input logic [91:0] v,
                                           input int step);
      beat_t e;
      int    nbeats;
      e = '0;
      nbeats = (int'(len) + 7) / 8;
      if (beat == 0) begin
         e.data = {cfg_da, cfg_sa[47:32]};
         e.sop  = 1'b1;
      end else if (beat == 1) begin
         e.data = {cfg_sa[31:0], len + 16'd2, seq};
         e.eop  = (len == 16'd0);             // Header-only frame
      end else begin
         if (cfg_rpay) begin
            e.data = v[63:0];
         end else begin
            for (int b = 0; b < 8; b++) begin
               e.data[8*b +: 8] = 8'((7 - b) + 8 * step);
            end
         end
         if (beat - 1 == nbeats) begin
            e.eop   = 1'b1;
            e.empty = 3'((8 - int'(len) % 8) % 8);
         end
      end
      return e;
   endfunction

   // ------------------------------------------------------------------------
   // Compare process, samples at the rising edge
   // ------------------------------------------------------------------------
   always @(posedge clk) begin
      beat_t exp_b;
      beat_t got_b;
      if (reset) begin
         frames_seen   = 0;
         stream_errors = 0;
         beat_idx      = 0;
      end else if (arm) begin
         lanes_m     = cfg_seed;
         pat_step    = 0;
         seq_m       = '0;
         beat_idx    = 0;
         frames_seen = 0;
         frame_len   = pick_len(cfg_seed);       // Lanes sit on the seed in idle
      end else if (tx_valid && tx_ready) begin
         exp_b = expected_beat(beat_idx, frame_len, seq_m, lanes_m, pat_step);
         got_b = {tx_data, tx_sop, tx_eop, tx_empty};
         if (got_b !== exp_b) begin
            stream_errors++;
            // Shown as data/sop eop/empty
            $display("error at %0t ns: frame %0d beat %0d got %h/%b%b/%0d, expected %h/%b%b/%0d",
                     $time, frames_seen, beat_idx, got_b.data, got_b.sop, got_b.eop,
                     got_b.empty, exp_b.data, exp_b.sop, exp_b.eop, exp_b.empty);
         end
         if (beat_idx == 1 && cfg_rlen && tx_data[31:16] >= 16'd1497) begin
            stream_errors++;
            $display("error at %0t ns: random length field %0d too large", $time,
                     tx_data[31:16]);
         end
         if (beat_idx >= 2) begin
            lanes_m = prbs_step(lanes_m);
            pat_step++;
         end
         if (exp_b.eop) begin
            frames_seen++;
            seq_m     = seq_m + 16'd1;
            beat_idx  = 0;
            frame_len = pick_len(lanes_m);       // Drawn in the gap
         end else begin
            beat_idx++;
         end
      end
   end

   // Readback and count comparisons asked for by the testbench
   task automatic compare_value(input string what, input int got, input int exp_v);
      if (got != exp_v) begin
         value_errors++;
         $display("error at %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, exp_v);
      end
   endtask

endmodule

// File: test/pktgen_tb.sv
/*
 Top testbench of the packet generator.
 Drives the register port and tx_ready, runs readback, fixed length,
 random, back-pressure and stop tests, and leaves the beat comparison
 to pktgen_checker. A watchdog bounds the run.
*/
`timescale 1ns/1ps
`include "pktgen_defines.svh"

module pktgen_tb;

   localparam int total_beats = 4500;                     // All runs, roughly
   localparam int timeout_ns  = (total_beats * 4 + 2000) * 20;

   logic        clk;
   logic        reset;
   logic [7:0]  address;
   logic        write;
   logic        read;
   logic [31:0] writedata;
   logic [31:0] readdata;
   logic        waitrequest;
   logic        tx_ready;
   logic [63:0] tx_data;
   logic        tx_valid;
   logic        tx_sop;
   logic        tx_eop;
   logic [2:0]  tx_empty;

   // Run settings mirrored for the checker
   logic        arm;
   logic [47:0] cfg_da;
   logic [47:0] cfg_sa;
   logic [13:0] cfg_len;
   logic        cfg_rlen;
   logic        cfg_rpay;
   logic [91:0] cfg_seed;
   logic        backpressure;
   logic [31:0] rd;
   int          stop_at;      // Frames done when stop is written

   pktgen_top dut (.*);

   pktgen_checker chk (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // tx_ready, random under back-pressure
   initial begin
      void'($urandom(32'hc6d5));
      tx_ready = 1'b1;
      forever begin
         @(posedge clk);
         #1 tx_ready = backpressure ? 1'($urandom % 2) : 1'b1;
      end
   end

   initial begin
      #(timeout_ns);
      $display("Timeout: the generator did not finish its runs in time");
      $display("Something failed");
      $finish;
   end

   // ------------------------------------------------------------------------
   // Register port driver
   // ------------------------------------------------------------------------
   task automatic reg_write(input logic [7:0] addr, input logic [31:0] value);
      @(posedge clk);
      #1;
      address   = addr;
      writedata = value;
      write     = 1'b1;
      do @(posedge clk); while (waitrequest);   // Hold until accepted
      #1 write = 1'b0;
   endtask

   task automatic reg_read(input logic [7:0] addr, output logic [31:0] value);
      @(posedge clk);
      #1;
      address = addr;
      read    = 1'b1;
      do @(posedge clk); while (waitrequest);
      value = readdata;                         // Valid once waitrequest drops
      #1 read = 1'b0;
   endtask

   task automatic read_and_compare(input string what, input logic [7:0] addr,
                                   input logic [31:0] exp_v);
      logic [31:0] got;
      reg_read(addr, got);
      chk.compare_value(what, int'(got), int'(exp_v));
   endtask

   // ------------------------------------------------------------------------
   // Run control
   // ------------------------------------------------------------------------
   task automatic setup_run(input int n, input logic [13:0] len, input logic rlen,
                            input logic rpay);
      cfg_len  = len;
      cfg_rlen = rlen;
      cfg_rpay = rpay;
      reg_write(`PKTGEN_ADDR_NUMPKTS, 32'(n));
      reg_write(`PKTGEN_ADDR_RANDOMLENGTH, {31'd0, rlen});
      reg_write(`PKTGEN_ADDR_RANDOMPAYLOAD, {31'd0, rpay});
      reg_write(`PKTGEN_ADDR_PKTLENGTH, {18'd0, len});
   endtask

   task automatic start_run();
      @(posedge clk);
      #1 arm = 1'b1;
      @(posedge clk);
      #1 arm = 1'b0;
      reg_write(`PKTGEN_ADDR_START, 32'd1);
   endtask

   // Idle once tx_valid stays low well past the one-cycle gap
   task automatic wait_idle();
      int quiet;
      quiet = 0;
      while (quiet < 8) begin
         @(posedge clk);
         if (tx_valid) quiet = 0;
         else quiet++;
      end
   endtask

   task automatic run_frames(input int n, input logic [13:0] len, input logic rlen,
                             input logic rpay, input logic bp);
      setup_run(n, len, rlen, rpay);
      backpressure = bp;
      start_run();
      while (chk.frames_seen < n) @(negedge clk);   // Last expected frame taken
      backpressure = 1'b0;
      wait_idle();
      chk.compare_value("frames seen", chk.frames_seen, n);
      read_and_compare("tx packet counter", `PKTGEN_ADDR_TXPKTCNT, 32'(n));
   endtask

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------
   initial begin
      reset        = 1'b1;
      address      = '0;
      write        = 1'b0;
      read         = 1'b0;
      writedata    = '0;
      arm          = 1'b0;
      backpressure = 1'b0;
      stop_at      = 0;
      cfg_da       = 48'hA1B2_C3D4_E5F6;
      cfg_sa       = 48'h0A0B_0C0D_0E0F;
      cfg_len      = '0;
      cfg_rlen     = 1'b0;
      cfg_rpay     = 1'b0;
      cfg_seed     = {`PKTGEN_SEED2_RST, `PKTGEN_SEED1_RST, `PKTGEN_SEED0_RST};
      repeat (4) @(posedge clk);
      #1 reset = 1'b0;

      // Readback, seeds first while still at reset values
      read_and_compare("seed 0", `PKTGEN_ADDR_RNDSEED0, 32'(`PKTGEN_SEED0_RST));
      read_and_compare("seed 1", `PKTGEN_ADDR_RNDSEED1, 32'(`PKTGEN_SEED1_RST));
      read_and_compare("seed 2", `PKTGEN_ADDR_RNDSEED2, 32'(`PKTGEN_SEED2_RST));
      reg_write(`PKTGEN_ADDR_MACDA0, cfg_da[31:0]);
      reg_write(`PKTGEN_ADDR_MACDA1, {16'd0, cfg_da[47:32]});
      reg_write(`PKTGEN_ADDR_MACSA0, cfg_sa[31:0]);
      reg_write(`PKTGEN_ADDR_MACSA1, {16'd0, cfg_sa[47:32]});
      setup_run(7, 14'd300, 1'b1, 1'b0);
      read_and_compare("mac da low", `PKTGEN_ADDR_MACDA0, cfg_da[31:0]);
      read_and_compare("mac da high", `PKTGEN_ADDR_MACDA1, {16'd0, cfg_da[47:32]});
      read_and_compare("mac sa low", `PKTGEN_ADDR_MACSA0, cfg_sa[31:0]);
      read_and_compare("mac sa high", `PKTGEN_ADDR_MACSA1, {16'd0, cfg_sa[47:32]});
      read_and_compare("packet count", `PKTGEN_ADDR_NUMPKTS, 32'd7);
      read_and_compare("packet length", `PKTGEN_ADDR_PKTLENGTH, 32'd300);
      read_and_compare("random length", `PKTGEN_ADDR_RANDOMLENGTH, 32'd1);
      read_and_compare("random payload", `PKTGEN_ADDR_RANDOMPAYLOAD, 32'd0);

      // Fixed lengths with the byte pattern, both clamps
      run_frames(3, 14'd20, 1'b0, 1'b0, 1'b0);
      run_frames(3, 14'd64, 1'b0, 1'b0, 1'b0);
      run_frames(2, 14'd9700, 1'b0, 1'b0, 1'b0);

      // Random length and payload from a written seed
      cfg_seed = {28'h0FE_DCBA, 32'h9ABC_DEF0, 32'h1234_5678};
      reg_write(`PKTGEN_ADDR_RNDSEED0, cfg_seed[31:0]);
      reg_write(`PKTGEN_ADDR_RNDSEED1, cfg_seed[63:32]);
      reg_write(`PKTGEN_ADDR_RNDSEED2, {4'd0, cfg_seed[91:64]});
      run_frames(6, 14'd0, 1'b1, 1'b1, 1'b0);

      // Back-pressure
      run_frames(5, 14'd200, 1'b0, 1'b1, 1'b1);
      run_frames(4, 14'd0, 1'b1, 1'b0, 1'b1);

      // Stop in the middle of a long run
      setup_run(1000, 14'd100, 1'b0, 1'b0);
      start_run();
      while (chk.frames_seen < 3) @(negedge clk);
      stop_at = chk.frames_seen;
      reg_write(`PKTGEN_ADDR_STOP, 32'd1);
      wait_idle();
      reg_read(`PKTGEN_ADDR_TXPKTCNT, rd);
      chk.compare_value("tx packet counter after stop", int'(rd), chk.frames_seen);
      chk.compare_value("frames before stop", chk.frames_seen, stop_at + 1);   // Frame in flight ends

      $display("Errors: stream %0d, value %0d", chk.stream_errors, chk.value_errors);
      if (chk.stream_errors == 0 && chk.value_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
